/* hw/procPkg.sv */
/*
 * procPkg
 * Shared types for the 16-bit single-cycle core: data word and register
 * index, the opcode map of the course ISA, ALU operations, write-back and
 * next-PC selects, and memory sizing
 */
`default_nettype none

package procPkg;

   typedef logic [15:0] wordT;
   typedef logic [2:0]  regIdxT;

   // Instruction and data memory depth
   localparam int MemWords    = 1024;
   localparam int MemAddrBits = 10;

   // Destination of JAL and JALR
   localparam regIdxT LinkReg = 3'd7;

   // Opcode field, instr[15:11]
   typedef enum logic [4:0] {
      opHalt  = 5'b00000,
      opNop   = 5'b00001,
      opJ     = 5'b00100,
      opJr    = 5'b00101,
      opJal   = 5'b00110,
      opJalr  = 5'b00111,
      opAddi  = 5'b01000,
      opSubi  = 5'b01001,
      opXori  = 5'b01010,
      opAndni = 5'b01011,
      opBeqz  = 5'b01100,
      opBnez  = 5'b01101,
      opBltz  = 5'b01110,
      opBgez  = 5'b01111,
      opSt    = 5'b10000,
      opLd    = 5'b10001,
      opSlbi  = 5'b10010,
      opRoli  = 5'b10100,
      opSlli  = 5'b10101,
      opRori  = 5'b10110,
      opSrli  = 5'b10111,
      opLbi   = 5'b11000,
      opShift = 5'b11010,   // ROL SLL ROR SRL by funct
      opArith = 5'b11011,   // ADD SUB XOR ANDN by funct
      opSeq   = 5'b11100,
      opSlt   = 5'b11101,
      opSle   = 5'b11110
   } opcodeE;

   // Low two bits of the first eight follow the funct / opcode order
   typedef enum logic [3:0] {
      aluAdd   = 4'd0,
      aluSub   = 4'd1,
      aluXor   = 4'd2,
      aluAndn  = 4'd3,
      aluRol   = 4'd4,
      aluSll   = 4'd5,
      aluRor   = 4'd6,
      aluSrl   = 4'd7,
      aluSeq   = 4'd8,
      aluSlt   = 4'd9,
      aluSle   = 4'd10,
      aluPassB = 4'd11,
      aluSlbi  = 4'd12
   } aluOpE;

   typedef enum logic [1:0] {
      wbAlu     = 2'd0,
      wbMem     = 2'd1,
      wbPcPlus2 = 2'd2
   } wbSrcE;

   typedef enum logic [2:0] {
      pcSeq     = 3'd0,
      pcBeqz    = 3'd1,
      pcBnez    = 3'd2,
      pcBltz    = 3'd3,
      pcBgez    = 3'd4,
      pcJumpRel = 3'd5,
      pcJumpReg = 3'd6
   } pcSelE;

endpackage

`default_nettype wire

/* hw/ctrlIf.sv */
/*
 * ctrlIf
 * Decoded control bundle, driven by the instruction decoder and read by
 * the execute unit and the next-PC unit
 */
`timescale 1ns/1ps
`default_nettype none

interface ctrlIf;

   procPkg::aluOpE  aluOp;
   logic            useImm;
   procPkg::wordT   imm;
   logic            regWrite;
   procPkg::regIdxT wrSel;
   procPkg::wbSrcE  wbSrc;
   logic            memEn;
   logic            memWrite;
   procPkg::pcSelE  pcSel;
   logic            halt;

   modport dec (output aluOp, useImm, imm, regWrite, wrSel, wbSrc,
                       memEn, memWrite, pcSel, halt);

   modport exe (input aluOp, useImm, imm, wbSrc, memEn, memWrite);

   modport pc (input pcSel, imm, halt);

endinterface

`default_nettype wire

/* hw/instrDecoder.sv */
/*
 * instrDecoder
 * Turns one instruction word into the control bundle: ALU operation,
 * operand and write-back selects, memory strobes, next-PC rule and the
 * extended immediate. Undefined opcodes raise err and execute as NOP
 */
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
   input  procPkg::wordT   instr,
   ctrlIf.dec              ctrl,
   output logic            regWrite,
   output procPkg::regIdxT wrSel,
   output logic            err
);

   procPkg::opcodeE opcode;
   logic [1:0]      funct;
   procPkg::wordT   zext5, sext5, zext8, sext8, sext11;

   assign opcode = procPkg::opcodeE'(instr[15:11]);
   assign funct  = instr[1:0];

   // Immediate candidates by field width
   assign zext5  = {11'b0, instr[4:0]};
   assign sext5  = {{11{instr[4]}}, instr[4:0]};
   assign zext8  = {8'b0, instr[7:0]};
   assign sext8  = {{8{instr[7]}}, instr[7:0]};
   assign sext11 = {{5{instr[10]}}, instr[10:0]};

   always_comb begin
      ctrl.aluOp    = procPkg::aluAdd;
      ctrl.useImm   = 1'b0;
      ctrl.imm      = '0;
      ctrl.regWrite = 1'b0;
      ctrl.wrSel    = instr[7:5];
      ctrl.wbSrc    = procPkg::wbAlu;
      ctrl.memEn    = 1'b0;
      ctrl.memWrite = 1'b0;
      ctrl.pcSel    = procPkg::pcSeq;
      ctrl.halt     = 1'b0;
      err           = 1'b0;
      case (opcode)
         procPkg::opHalt: ctrl.halt = 1'b1;
         procPkg::opNop: ;
         procPkg::opAddi, procPkg::opSubi: begin
            ctrl.aluOp    = procPkg::aluOpE'({2'b00, instr[12:11]});
            ctrl.useImm   = 1'b1;
            ctrl.imm      = sext5;
            ctrl.regWrite = 1'b1;
         end
         procPkg::opXori, procPkg::opAndni: begin
            ctrl.aluOp    = procPkg::aluOpE'({2'b00, instr[12:11]});
            ctrl.useImm   = 1'b1;
            ctrl.imm      = zext5;
            ctrl.regWrite = 1'b1;
         end
         procPkg::opRoli, procPkg::opSlli, procPkg::opRori, procPkg::opSrli: begin
            ctrl.aluOp    = procPkg::aluOpE'({2'b01, instr[12:11]});
            ctrl.useImm   = 1'b1;
            ctrl.imm      = zext5;
            ctrl.regWrite = 1'b1;
         end
         procPkg::opSt, procPkg::opLd: begin
            // Address is Rs + imm, store data comes from Rd
            ctrl.useImm   = 1'b1;
            ctrl.imm      = sext5;
            ctrl.memEn    = 1'b1;
            ctrl.memWrite = (opcode == procPkg::opSt);
            ctrl.regWrite = (opcode == procPkg::opLd);
            ctrl.wbSrc    = procPkg::wbMem;
         end
         procPkg::opArith, procPkg::opShift: begin
            ctrl.aluOp    = procPkg::aluOpE'({1'b0, ~instr[11], funct});
            ctrl.regWrite = 1'b1;
            ctrl.wrSel    = instr[4:2];
         end
         procPkg::opSeq, procPkg::opSlt, procPkg::opSle: begin
            ctrl.aluOp    = procPkg::aluOpE'({2'b10, instr[12:11]});
            ctrl.regWrite = 1'b1;
            ctrl.wrSel    = instr[4:2];
         end
         procPkg::opBeqz, procPkg::opBnez, procPkg::opBltz, procPkg::opBgez: begin
            ctrl.imm   = {sext8[14:0], 1'b0};
            ctrl.pcSel = procPkg::pcSelE'({1'b0, instr[12:11]} + 3'd1);
         end
         procPkg::opLbi, procPkg::opSlbi: begin
            ctrl.aluOp    = (opcode == procPkg::opLbi) ? procPkg::aluPassB : procPkg::aluSlbi;
            ctrl.useImm   = 1'b1;
            ctrl.imm      = (opcode == procPkg::opLbi) ? sext8 : zext8;
            ctrl.regWrite = 1'b1;
            ctrl.wrSel    = instr[10:8];
         end
         procPkg::opJ, procPkg::opJal: begin
            ctrl.imm      = {sext11[14:0], 1'b0};
            ctrl.pcSel    = procPkg::pcJumpRel;
            ctrl.regWrite = (opcode == procPkg::opJal);
            ctrl.wrSel    = procPkg::LinkReg;
            ctrl.wbSrc    = procPkg::wbPcPlus2;
         end
         procPkg::opJr, procPkg::opJalr: begin
            ctrl.imm      = {sext8[14:0], 1'b0};
            ctrl.pcSel    = procPkg::pcJumpReg;
            ctrl.regWrite = (opcode == procPkg::opJalr);
            ctrl.wrSel    = procPkg::LinkReg;
            ctrl.wbSrc    = procPkg::wbPcPlus2;
         end
         default: err = 1'b1;
      endcase
   end

   // Register-file write goes out as plain wires as well
   assign regWrite = ctrl.regWrite;
   assign wrSel    = ctrl.wrSel;

endmodule

`default_nettype wire

/* hw/regFile.sv */
/*
 * regFile
 * Eight 16-bit general registers, two asynchronous read ports and one
 * write port that commits on the clock edge
 */
`timescale 1ns/1ps
`default_nettype none

module regFile (
   input  logic            clk,
   input  logic            rst,
   input  procPkg::regIdxT rdSel1,
   input  procPkg::regIdxT rdSel2,
   input  procPkg::regIdxT wrSel,
   input  procPkg::wordT   wrData,
   input  logic            wrEn,
   output procPkg::wordT   rdData1,
   output procPkg::wordT   rdData2
);

   procPkg::wordT regs [8];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrSel] <= wrData;
      end
   end

   // Reads settle before the writing edge so no bypass is needed
   assign rdData1 = regs[rdSel1];
   assign rdData2 = regs[rdSel2];

endmodule

`default_nettype wire

/* hw/execUnit.sv */
/*
 * execUnit
 * Second-operand select, ALU, data-memory address and store data, and
 * the write-back source select
 */
`timescale 1ns/1ps
`default_nettype none

module execUnit (
   ctrlIf.exe            ctrl,
   input  procPkg::wordT opA,
   input  procPkg::wordT opB,
   input  procPkg::wordT pcPlus2,
   input  procPkg::wordT memRdData,
   output procPkg::wordT memAddr,
   output procPkg::wordT memWrData,
   output procPkg::wordT wbData,
   output procPkg::wordT aluOut
);

   procPkg::wordT aluB;
   logic [3:0]    shAmt;
   logic [31:0]   rolWide, rorWide;

   assign aluB  = ctrl.useImm ? ctrl.imm : opB;
   assign shAmt = aluB[3:0];

   // Rotates through a doubled copy of A
   assign rolWide = {opA, opA} << shAmt;
   assign rorWide = {opA, opA} >> shAmt;

   always_comb begin
      case (ctrl.aluOp)
         procPkg::aluAdd:   aluOut = opA + aluB;
         // SUB and SUBI compute B minus A
         procPkg::aluSub:   aluOut = aluB - opA;
         procPkg::aluXor:   aluOut = opA ^ aluB;
         procPkg::aluAndn:  aluOut = opA & ~aluB;
         procPkg::aluRol:   aluOut = rolWide[31:16];
         procPkg::aluSll:   aluOut = opA << shAmt;
         procPkg::aluRor:   aluOut = rorWide[15:0];
         procPkg::aluSrl:   aluOut = opA >> shAmt;
         procPkg::aluSeq:   aluOut = {15'b0, opA == aluB};
         procPkg::aluSlt:   aluOut = {15'b0, $signed(opA) < $signed(aluB)};
         procPkg::aluSle:   aluOut = {15'b0, $signed(opA) <= $signed(aluB)};
         procPkg::aluPassB: aluOut = aluB;
         procPkg::aluSlbi:  aluOut = {opA[7:0], 8'h00} | aluB;
         default:           aluOut = '0;
      endcase
   end

   // Data bus stays quiet unless a load or store is in flight
   assign memAddr   = ctrl.memEn ? aluOut : '0;
   assign memWrData = ctrl.memWrite ? opB : '0;

   always_comb begin
      case (ctrl.wbSrc)
         procPkg::wbMem:     wbData = memRdData;
         procPkg::wbPcPlus2: wbData = pcPlus2;
         default:            wbData = aluOut;
      endcase
   end

endmodule

`default_nettype wire

/* hw/nextPc.sv */
/*
 * nextPc
 * Program counter with its PC+2 adder, branch and jump target selection,
 * and the stop on HALT
 */
`timescale 1ns/1ps
`default_nettype none

module nextPc (
   input  logic          clk,
   input  logic          rst,
   ctrlIf.pc             ctrl,
   input  procPkg::wordT regA,
   output procPkg::wordT pc,
   output procPkg::wordT pcPlus2
);

   procPkg::wordT relTarget, regTarget, pcNext;
   logic          isZero, isNeg;

   assign pcPlus2   = pc + 16'd2;
   assign relTarget = pcPlus2 + ctrl.imm;
   assign regTarget = regA + ctrl.imm;

   assign isZero = (regA == '0);
   assign isNeg  = regA[15];

   always_comb begin
      pcNext = pcPlus2;
      case (ctrl.pcSel)
         procPkg::pcBeqz:    if (isZero) pcNext = relTarget;
         procPkg::pcBnez:    if (!isZero) pcNext = relTarget;
         procPkg::pcBltz:    if (isNeg) pcNext = relTarget;
         procPkg::pcBgez:    if (!isNeg) pcNext = relTarget;
         procPkg::pcJumpRel: pcNext = relTarget;
         procPkg::pcJumpReg: pcNext = regTarget;
         default: ;
      endcase
   end

   // Halt freezes the PC on the HALT word
   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= '0;
      end else if (!ctrl.halt) begin
         pc <= pcNext;
      end
   end

endmodule

`default_nettype wire

/* hw/wordMem.sv */
/*
 * wordMem
 * Word-wide memory addressed by byte address with bit 0 dropped.
 * Asynchronous read, write on the clock edge
 */
`timescale 1ns/1ps
`default_nettype none

module wordMem (
   input  logic          clk,
   input  logic          rst,
   input  procPkg::wordT addr,
   input  procPkg::wordT wrData,
   input  logic          wrEn,
   output procPkg::wordT rdData
);

   procPkg::wordT                   mem [procPkg::MemWords];
   logic [procPkg::MemAddrBits-1:0] wordIdx;

   assign wordIdx = addr[procPkg::MemAddrBits:1];

   // Contents survive reset so a loaded program stays in place
   always_ff @(posedge clk) begin
      if (wrEn) begin
         mem[wordIdx] <= wrData;
      end
   end

   // Reads as zero in reset so unloaded words never reach the core
   assign rdData = rst ? '0 : mem[wordIdx];

endmodule

`default_nettype wire

/* hw/proc.sv */
/*
 * proc
 * Single-cycle 16-bit processor. Fetch, decode, register read, execute,
 * memory access, write-back and PC update all finish in one clock.
 * Program words enter instruction memory through the load port while
 * rst is high; register writes are visible on the trace outputs
 */
`timescale 1ns/1ps
`default_nettype none

module proc (
   input  logic            clk,
   input  logic            rst,
   input  logic            progWrEn,
   input  procPkg::wordT   progAddr,
   input  procPkg::wordT   progData,
   output logic            err,
   output logic            halted,
   output logic            wbValid,
   output procPkg::regIdxT wbReg,
   output procPkg::wordT   wbData
);

   procPkg::wordT   instr, pc, pcPlus2, instAddr;
   procPkg::wordT   rdData1, rdData2;
   procPkg::wordT   memAddr, memWrData, memRdData;
   logic            regWrite, dataWrEn;
   procPkg::regIdxT wrSel;

   ctrlIf ctrl ();

   // Load port owns instruction memory during reset
   assign instAddr = rst ? progAddr : pc;

   wordMem instMem (
      .clk    (clk),
      .rst    (rst),
      .addr   (instAddr),
      .wrData (progData),
      .wrEn   (progWrEn & rst),
      .rdData (instr)
   );

   instrDecoder decoder (
      .instr    (instr),
      .ctrl     (ctrl.dec),
      .regWrite (regWrite),
      .wrSel    (wrSel),
      .err      (err)
   );

   // Trace mirrors the register-file write port
   assign wbValid = regWrite & ~rst;
   assign wbReg   = wrSel;
   assign halted  = ctrl.halt & ~rst;

   regFile regs (
      .clk     (clk),
      .rst     (rst),
      .rdSel1  (instr[10:8]),
      .rdSel2  (instr[7:5]),
      .wrSel   (wrSel),
      .wrData  (wbData),
      .wrEn    (wbValid),
      .rdData1 (rdData1),
      .rdData2 (rdData2)
   );

   // ALU result reaches data memory through memAddr
   execUnit exec (
      .ctrl      (ctrl.exe),
      .opA       (rdData1),
      .opB       (rdData2),
      .pcPlus2   (pcPlus2),
      .memRdData (memRdData),
      .memAddr   (memAddr),
      .memWrData (memWrData),
      .wbData    (wbData),
      .aluOut    ()
   );

   assign dataWrEn = ctrl.memEn & ctrl.memWrite & ~rst;

   wordMem dataMem (
      .clk    (clk),
      .rst    (rst),
      .addr   (memAddr),
      .wrData (memWrData),
      .wrEn   (dataWrEn),
      .rdData (memRdData)
   );

   nextPc pcUnit (
      .clk     (clk),
      .rst     (rst),
      .ctrl    (ctrl.pc),
      .regA    (rdData1),
      .pc      (pc),
      .pcPlus2 (pcPlus2)
   );

endmodule

`default_nettype wire

/* bench/isaModel.svh */
/*
 * isaModel
 * Instruction-level reference model of the core: its own registers,
 * instruction and data memories and PC, stepped one instruction at a time
 */
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

procPkg::wordT mRegs [8];
procPkg::wordT mMem  [procPkg::MemWords];
procPkg::wordT mImem [procPkg::MemWords];
procPkg::wordT mPc;

function automatic procPkg::wordT rotateLeft(procPkg::wordT x, int n);
   return (x << n) | (x >> (16 - n));
endfunction

function automatic procPkg::wordT rotateRight(procPkg::wordT x, int n);
   return (x >> n) | (x << (16 - n));
endfunction

function automatic void clearModel();
   for (int i = 0; i < 8; i++) begin
      mRegs[i] = '0;
   end
   for (int i = 0; i < procPkg::MemWords; i++) begin
      mMem[i]  = '0;
      mImem[i] = '0;
   end
   mPc = '0;
endfunction

// One instruction: expected register write, halt and illegal flags
function automatic void isaStep(output logic wrEn, output procPkg::regIdxT wrReg,
                                output procPkg::wordT wrVal, output logic halt,
                                output logic illegal);
   procPkg::wordT   instr, a, b, sImm5, zImm5, brOff, jOff, addr, seqPc, npc;
   procPkg::opcodeE op;
   logic            noWrite;
   instr = mImem[mPc[procPkg::MemAddrBits:1]];
   op    = procPkg::opcodeE'(instr[15:11]);
   a     = mRegs[instr[10:8]];
   b     = mRegs[instr[7:5]];
   sImm5 = {{11{instr[4]}}, instr[4:0]};
   zImm5 = {11'h000, instr[4:0]};
   brOff = {{7{instr[7]}}, instr[7:0], 1'b0};
   jOff  = {{4{instr[10]}}, instr[10:0], 1'b0};
   addr  = a + sImm5;
   seqPc = mPc + 16'd2;
   npc   = seqPc;
   // Link value unless a result below replaces it
   wrVal   = seqPc;
   illegal = 1'b0;
   case (op)
      procPkg::opHalt:  npc = mPc;
      procPkg::opNop:   ;
      procPkg::opAddi:  wrVal = a + sImm5;
      procPkg::opSubi:  wrVal = sImm5 - a;
      procPkg::opXori:  wrVal = a ^ zImm5;
      procPkg::opAndni: wrVal = a & ~zImm5;
      procPkg::opRoli:  wrVal = rotateLeft(a, instr[3:0]);
      procPkg::opSlli:  wrVal = a << instr[3:0];
      procPkg::opRori:  wrVal = rotateRight(a, instr[3:0]);
      procPkg::opSrli:  wrVal = a >> instr[3:0];
      procPkg::opSt:    mMem[addr[procPkg::MemAddrBits:1]] = b;
      procPkg::opLd:    wrVal = mMem[addr[procPkg::MemAddrBits:1]];
      procPkg::opSlbi:  wrVal = (a << 8) | {8'h00, instr[7:0]};
      procPkg::opLbi:   wrVal = {{8{instr[7]}}, instr[7:0]};
      procPkg::opArith: begin
         case (instr[1:0])
            2'd0:    wrVal = a + b;
            2'd1:    wrVal = b - a;
            2'd2:    wrVal = a ^ b;
            default: wrVal = a & ~b;
         endcase
      end
      procPkg::opShift: begin
         case (instr[1:0])
            2'd0:    wrVal = rotateLeft(a, b[3:0]);
            2'd1:    wrVal = a << b[3:0];
            2'd2:    wrVal = rotateRight(a, b[3:0]);
            default: wrVal = a >> b[3:0];
         endcase
      end
      procPkg::opSeq:   wrVal = {15'h0000, a == b};
      procPkg::opSlt:   wrVal = {15'h0000, $signed(a) < $signed(b)};
      procPkg::opSle:   wrVal = {15'h0000, $signed(a) <= $signed(b)};
      procPkg::opBeqz:  if (a == 16'h0000) npc = seqPc + brOff;
      procPkg::opBnez:  if (a != 16'h0000) npc = seqPc + brOff;
      procPkg::opBltz:  if (a[15]) npc = seqPc + brOff;
      procPkg::opBgez:  if (!a[15]) npc = seqPc + brOff;
      procPkg::opJ, procPkg::opJal:   npc = seqPc + jOff;
      procPkg::opJr, procPkg::opJalr: npc = a + brOff;
      default:          illegal = 1'b1;
   endcase
   // Destination by instruction format
   case (op)
      procPkg::opLbi, procPkg::opSlbi: wrReg = instr[10:8];
      procPkg::opArith, procPkg::opShift, procPkg::opSeq, procPkg::opSlt,
      procPkg::opSle:                  wrReg = instr[4:2];
      procPkg::opJal, procPkg::opJalr: wrReg = procPkg::LinkReg;
      default:                         wrReg = instr[7:5];
   endcase
   case (op)
      procPkg::opHalt, procPkg::opNop, procPkg::opSt, procPkg::opJ, procPkg::opJr,
      procPkg::opBeqz, procPkg::opBnez, procPkg::opBltz, procPkg::opBgez: noWrite = 1'b1;
      default: noWrite = illegal;
   endcase
   wrEn = !noWrite;
   halt = (op == procPkg::opHalt);
   if (wrEn) begin
      mRegs[wrReg] = wrVal;
   end
   mPc = npc;
endfunction

`endif

/* bench/procTb.sv */
/*
 * procTb
 * Loads a test program through the load port, then checks every traced
 * register write, halt and illegal-opcode flag against the ISA model
 */
`timescale 1ns/1ps
`default_nettype none

module procTb;

   localparam int HaltTimeout    = 400;
   localparam int PostHaltCycles = 20;

   logic            clk, rst, progWrEn;
   procPkg::wordT   progAddr, progData;
   logic            err, halted, wbValid;
   procPkg::regIdxT wbReg;
   procPkg::wordT   wbData;

   integer          errors, seed, writes, errCycles, cyc;
   procPkg::wordT   prog [$];

   // Model results for the instruction of the current cycle
   logic            expWr, expHalt, expErr;
   procPkg::regIdxT expReg;
   procPkg::wordT   expVal;

   `include "isaModel.svh"

   proc DUT (
      .clk      (clk),
      .rst      (rst),
      .progWrEn (progWrEn),
      .progAddr (progAddr),
      .progData (progData),
      .err      (err),
      .halted   (halted),
      .wbValid  (wbValid),
      .wbReg    (wbReg),
      .wbData   (wbData)
   );

   always #4 clk = ~clk;

   function automatic procPkg::wordT encodeImm5(procPkg::opcodeE op, procPkg::regIdxT rs,
                                                procPkg::regIdxT rd, logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic procPkg::wordT encodeReg(procPkg::opcodeE op, procPkg::regIdxT rs,
                                               procPkg::regIdxT rt, procPkg::regIdxT rd,
                                               logic [1:0] funct);
      return {op, rs, rt, rd, funct};
   endfunction

   function automatic procPkg::wordT encodeImm8(procPkg::opcodeE op, procPkg::regIdxT rs,
                                                logic [7:0] imm);
      return {op, rs, imm};
   endfunction

   function automatic procPkg::wordT encodeJump(procPkg::opcodeE op, logic [10:0] off);
      return {op, off};
   endfunction

   function automatic logic [7:0] randomByte();
      integer r;
      r = $random(seed);
      return r[7:0];
   endfunction

   function automatic void appendWord(procPkg::wordT w);
      prog.push_back(w);
   endfunction

   // Control transfer over one trap word to a marker write
   function automatic void appendSkip(procPkg::wordT ctlWord, logic [7:0] mark);
      appendWord(ctlWord);
      appendWord(encodeImm8(procPkg::opLbi, 3'd5, 8'h5a));
      appendWord(encodeImm8(procPkg::opLbi, 3'd5, mark));
   endfunction

   // Register jump through r6 set to 4 lands past the trap word
   function automatic void appendRegJump(procPkg::opcodeE op, logic [7:0] mark);
      procPkg::wordT here;
      appendWord(encodeImm8(procPkg::opLbi, 3'd6, 8'd4));
      here = procPkg::wordT'(prog.size() * 2);
      appendSkip(encodeImm8(op, 3'd6, here[8:1]), mark);
   endfunction

   task automatic buildProgram();
      appendWord(encodeImm8(procPkg::opLbi, 3'd1, randomByte()));
      appendWord(encodeImm8(procPkg::opLbi, 3'd2, randomByte()));
      appendWord(encodeImm8(procPkg::opSlbi, 3'd1, randomByte()));
      appendWord(encodeImm8(procPkg::opSlbi, 3'd2, randomByte()));
      appendWord(encodeImm8(procPkg::opLbi, 3'd3, 8'd5));
      appendWord(encodeImm8(procPkg::opLbi, 3'd4, 8'hf3));
      // Immediate ALU forms
      appendWord(encodeImm5(procPkg::opAddi, 3'd1, 3'd5, 5'h13));
      appendWord(encodeImm5(procPkg::opSubi, 3'd1, 3'd5, 5'h07));
      appendWord(encodeImm5(procPkg::opSubi, 3'd4, 3'd5, 5'h1e));
      appendWord(encodeImm5(procPkg::opXori, 3'd2, 3'd5, 5'h1b));
      appendWord(encodeImm5(procPkg::opAndni, 3'd1, 3'd5, 5'h0f));
      appendWord(encodeImm5(procPkg::opRoli, 3'd1, 3'd5, 5'd3));
      appendWord(encodeImm5(procPkg::opRoli, 3'd2, 3'd5, 5'h10));
      appendWord(encodeImm5(procPkg::opSlli, 3'd1, 3'd5, 5'd9));
      appendWord(encodeImm5(procPkg::opRori, 3'd2, 3'd5, 5'd13));
      appendWord(encodeImm5(procPkg::opSrli, 3'd4, 3'd5, 5'd4));
      // Register ALU forms and compares
      appendWord(encodeReg(procPkg::opArith, 3'd1, 3'd2, 3'd5, 2'd0));
      appendWord(encodeReg(procPkg::opArith, 3'd1, 3'd2, 3'd5, 2'd1));
      appendWord(encodeReg(procPkg::opArith, 3'd1, 3'd2, 3'd5, 2'd2));
      appendWord(encodeReg(procPkg::opArith, 3'd1, 3'd2, 3'd5, 2'd3));
      appendWord(encodeReg(procPkg::opShift, 3'd1, 3'd3, 3'd5, 2'd0));
      appendWord(encodeReg(procPkg::opShift, 3'd1, 3'd3, 3'd5, 2'd1));
      appendWord(encodeReg(procPkg::opShift, 3'd2, 3'd4, 3'd5, 2'd2));
      appendWord(encodeReg(procPkg::opShift, 3'd4, 3'd3, 3'd5, 2'd3));
      appendWord(encodeReg(procPkg::opSeq, 3'd1, 3'd1, 3'd5, 2'd0));
      appendWord(encodeReg(procPkg::opSeq, 3'd1, 3'd2, 3'd5, 2'd0));
      appendWord(encodeReg(procPkg::opSlt, 3'd4, 3'd3, 3'd5, 2'd0));
      appendWord(encodeReg(procPkg::opSlt, 3'd3, 3'd4, 3'd5, 2'd0));
      appendWord(encodeReg(procPkg::opSle, 3'd3, 3'd3, 3'd5, 2'd0));
      appendWord(encodeReg(procPkg::opSle, 3'd1, 3'd2, 3'd5, 2'd0));
      // Stores at three addresses and loads back in another order
      appendWord(encodeImm8(procPkg::opLbi, 3'd6, 8'h40));
      appendWord(encodeImm5(procPkg::opSt, 3'd6, 3'd1, 5'd0));
      appendWord(encodeImm5(procPkg::opSt, 3'd6, 3'd2, 5'd6));
      appendWord(encodeImm5(procPkg::opSt, 3'd6, 3'd4, 5'h1c));
      appendWord(encodeImm5(procPkg::opLd, 3'd6, 3'd5, 5'd0));
      appendWord(encodeImm5(procPkg::opLd, 3'd6, 3'd7, 5'h1c));
      appendWord(encodeImm5(procPkg::opLd, 3'd6, 3'd5, 5'd6));
      // Taken and untaken branches on r0 zero, r3 positive and r4 negative
      appendSkip(encodeImm8(procPkg::opBeqz, 3'd0, 8'd1), 8'h01);
      appendSkip(encodeImm8(procPkg::opBeqz, 3'd3, 8'd1), 8'h02);
      appendSkip(encodeImm8(procPkg::opBnez, 3'd3, 8'd1), 8'h03);
      appendSkip(encodeImm8(procPkg::opBnez, 3'd0, 8'd1), 8'h04);
      appendSkip(encodeImm8(procPkg::opBltz, 3'd4, 8'd1), 8'h05);
      appendSkip(encodeImm8(procPkg::opBltz, 3'd3, 8'd1), 8'h06);
      appendSkip(encodeImm8(procPkg::opBgez, 3'd3, 8'd1), 8'h07);
      appendSkip(encodeImm8(procPkg::opBgez, 3'd4, 8'd1), 8'h08);
      appendSkip(encodeImm8(procPkg::opBgez, 3'd0, 8'd1), 8'h09);
      // Jumps
      appendSkip(encodeJump(procPkg::opJ, 11'd1), 8'h0a);
      appendSkip(encodeJump(procPkg::opJal, 11'd1), 8'h0b);
      appendRegJump(procPkg::opJr, 8'h0c);
      appendRegJump(procPkg::opJalr, 8'h0d);
      // Undefined opcode and NOP before a write that shows execution goes on
      appendWord({5'b00010, 11'h000});
      appendWord(encodeJump(procPkg::opNop, 11'h000));
      appendWord(encodeImm8(procPkg::opLbi, 3'd5, 8'h0e));
      appendWord(encodeJump(procPkg::opHalt, 11'h000));
      appendWord(encodeImm8(procPkg::opLbi, 3'd5, 8'h5a));
   endtask

   task automatic checkWrite(input logic gotValid, input logic expValid,
                             input procPkg::regIdxT gotReg, input procPkg::regIdxT expRegIdx,
                             input procPkg::wordT gotData, input procPkg::wordT expData);
      if (gotValid !== expValid) begin
         $display("** Error wbValid: got %h expected %h at %0t", gotValid, expValid, $time);
         errors++;
      end else if (expValid && gotReg !== expRegIdx) begin
         $display("** Error wbReg: got %h expected %h at %0t", gotReg, expRegIdx, $time);
         errors++;
      end else if (expValid && gotData !== expData) begin
         $display("** Error wbData: got %h expected %h at %0t", gotData, expData, $time);
         errors++;
      end
   endtask

   task automatic checkHalt(input logic got, input logic exp);
      if (got !== exp) begin
         $display("** Error halted: got %h expected %h at %0t", got, exp, $time);
         errors++;
      end
   endtask

   task automatic checkErr(input logic got, input logic exp);
      if (got !== exp) begin
         $display("** Error err: got %h expected %h at %0t", got, exp, $time);
         errors++;
      end
   endtask

   // Trace is valid before the committing edge
   always @(posedge clk) begin
      if (!rst) begin
         isaStep(expWr, expReg, expVal, expHalt, expErr);
         checkWrite(wbValid, expWr, wbReg, expReg, wbData, expVal);
         checkHalt(halted, expHalt);
         checkErr(err, expErr);
         if (wbValid) writes++;
         if (err) errCycles++;
      end
   end

   initial begin
      clk       = 1'b0;
      rst       = 1'b1;
      progWrEn  = 1'b0;
      progAddr  = '0;
      progData  = '0;
      errors    = 0;
      writes    = 0;
      errCycles = 0;
      seed      = 32'ha962;
      clearModel();
      buildProgram();
      for (int i = 0; i < prog.size(); i++) begin
         @(posedge clk);
         #1;
         progWrEn = 1'b1;
         progAddr = procPkg::wordT'(i * 2);
         progData = prog[i];
         mImem[i] = prog[i];
      end
      @(posedge clk);
      #1;
      progWrEn = 1'b0;
      // Reset stays high for 3 more cycles
      repeat (3) @(posedge clk);
      #1;
      rst = 1'b0;
      for (cyc = 0; cyc < HaltTimeout && !halted; cyc++) begin
         @(posedge clk);
         #2;
      end
      if (!halted) begin
         $display("Timed out after %0d cycles waiting for the core to halt", cyc);
         errors++;
      end else begin
         for (cyc = 0; cyc < PostHaltCycles; cyc++) begin
            @(posedge clk);
            #2;
            if (wbValid) begin
               $display("Register write traced %0d cycles after HALT", cyc + 1);
               errors++;
            end
            if (!halted) begin
               $display("Halted output dropped %0d cycles after HALT", cyc + 1);
               errors++;
            end
         end
         if (errCycles != 1) begin
            $display("Undefined opcode flagged in %0d cycles instead of one", errCycles);
            errors++;
         end
      end
      $display("Run complete, %0d traced writes, %0d error(s)", writes, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* proc.f */
+incdir+bench
hw/procPkg.sv
hw/ctrlIf.sv
hw/instrDecoder.sv
hw/regFile.sv
hw/execUnit.sv
hw/nextPc.sv
hw/wordMem.sv
hw/proc.sv
bench/procTb.sv
